// File: design/axis_pkg.sv
// ##################################################
// Shared types and register map of the position axis
// Imported by every RTL block and by the testbench
// ##################################################
`default_nettype none

package axis_pkg;

  localparam int POS_W  = 32;  // Position counter width
  localparam int ADDR_W = 3;   // Register address width
  localparam int DATA_W = 32;  // Register data width

  typedef logic signed [POS_W-1:0] pos_t;  // Signed position in steps
  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0] reg_data_t;

  // Control register, enable sits in bit 0
  typedef struct packed {
    logic limit_en;          // Bit 4, fault may set
    logic probe_rising;      // Bit 3, capture on rising probe edge
    logic invert_dir;        // Bit 2, swap count direction
    logic step_active_high;  // Bit 1, count on rising step edge
    logic enable;            // Bit 0, counting allowed
  } axis_cfg_t;

  // Status register, probe_valid sits in bit 0
  typedef struct packed {
    logic fault;        // Bit 3, sticky limit fault
    logic above_high;   // Bit 2
    logic below_low;    // Bit 1
    logic probe_valid;  // Bit 0, capture holds a position
  } axis_status_t;

  localparam reg_addr_t ADDR_CTRL       = 3'd0;
  localparam reg_addr_t ADDR_POSITION   = 3'd1;
  localparam reg_addr_t ADDR_LIMIT_LOW  = 3'd2;
  localparam reg_addr_t ADDR_LIMIT_HIGH = 3'd3;
  localparam reg_addr_t ADDR_PROBE_POS  = 3'd4;
  localparam reg_addr_t ADDR_STATUS     = 3'd5;

  localparam pos_t POS_MIN = {1'b1, {(POS_W-1){1'b0}}};  // Most negative position
  localparam pos_t POS_MAX = {1'b0, {(POS_W-1){1'b1}}};  // Most positive position

endpackage

`default_nettype wire

// File: design/pos_counter.sv
// ##################################################
// Signed position counter fed by step/dir lines of
// an external stepper driver. Step polarity and the
// direction sense come from the control register,
// a register write presets the count
// ##################################################
`default_nettype none

module pos_counter import axis_pkg::*; #(
  parameter int SYNC_STAGES = 2  // Synchronizer depth, two or more
) (
  input  logic      clk,
  input  logic      resetn,
  input  logic      step,        // Asynchronous step level
  input  logic      dir,         // Asynchronous direction level
  input  axis_cfg_t cfg,
  input  logic      load,        // Preset strobe from the register bank
  input  pos_t      load_value,
  output pos_t      position
);

  logic [SYNC_STAGES:0] step_sr;  // Step samples, bit 0 is the newest
  logic [SYNC_STAGES:0] dir_sr;   // Direction samples, same depth as step
  logic                 step_change;
  logic                 level_ok;
  logic                 stepped;
  logic                 count_hit;  // Registered step event
  logic                 count_up;

  // Level change between the two oldest samples
  assign step_change = step_sr[SYNC_STAGES] ^ step_sr[SYNC_STAGES-1];

  // New level has to match the selected polarity
  assign level_ok = ~(step_sr[SYNC_STAGES-1] ^ cfg.step_active_high);
  assign stepped  = step_change & level_ok;

  // Oldest dir sample lines up with the registered event
  assign count_up = dir_sr[SYNC_STAGES] ^ cfg.invert_dir;

  always_ff @(posedge clk) begin
    step_sr <= {step_sr[SYNC_STAGES-1:0], step};  // Shift in at the bottom
    dir_sr  <= {dir_sr[SYNC_STAGES-1:0], dir};
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count_hit <= 1'b0;
      position  <= '0;
    end else begin
      count_hit <= stepped;  // One extra stage before the count
      if (load) begin
        position <= load_value;  // Preset beats a step
      end else if (count_hit && cfg.enable) begin
        if (count_up) begin
          position <= position + pos_t'(1);
        end else begin
          position <= position - pos_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/probe_latch.sv
// ##################################################
// Touch probe capture. Synchronizes the probe line,
// picks the edge set in the control register and
// latches the position once until re-armed
// ##################################################
`default_nettype none

module probe_latch import axis_pkg::*; #(
  parameter int SYNC_STAGES = 2  // Synchronizer depth, two or more
) (
  input  logic      clk,
  input  logic      resetn,
  input  logic      probe,        // Asynchronous probe level
  input  axis_cfg_t cfg,
  input  pos_t      position,
  input  logic      probe_clear,  // Re-arm strobe, W1C on STATUS bit 0
  output pos_t      probe_pos,
  output logic      probe_valid
);

  logic [SYNC_STAGES:0] probe_sr;  // Probe samples, bit 0 is the newest
  logic                 probe_change;
  logic                 probe_edge;
  logic                 probe_hit;  // Registered edge event

  assign probe_change = probe_sr[SYNC_STAGES] ^ probe_sr[SYNC_STAGES-1];
  assign probe_edge   = probe_change & ~(probe_sr[SYNC_STAGES-1] ^ cfg.probe_rising);

  always_ff @(posedge clk) begin
    probe_sr <= {probe_sr[SYNC_STAGES-1:0], probe};
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      probe_hit   <= 1'b0;
      probe_valid <= 1'b0;
      probe_pos   <= '0;  // Reads as zero until the first capture
    end else begin
      probe_hit <= probe_edge;
      if (probe_clear) begin
        probe_valid <= 1'b0;  // Clear wins over a capture
      end else if (probe_hit && !probe_valid) begin
        probe_valid <= 1'b1;
        probe_pos   <= position;  // First edge only
      end
    end
  end

endmodule

`default_nettype wire

// File: design/limit_monitor.sv
// ##################################################
// Soft limit monitor. Compares the position against
// a signed window and keeps a sticky fault that only
// a STATUS write of bit 3 releases
// ##################################################
`default_nettype none

module limit_monitor import axis_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  pos_t      position,
  input  pos_t      low_limit,
  input  pos_t      high_limit,
  input  axis_cfg_t cfg,
  input  logic      fault_clear,  // W1C on STATUS bit 3
  output logic      below_low,
  output logic      above_high,
  output logic      fault
);

  logic below_now;  // Compare result of this cycle
  logic above_now;
  logic trip;

  // Both sides are pos_t, so the compares are signed
  assign below_now = position < low_limit;
  assign above_now = position > high_limit;

  // A new fault shows up together with the flags
  assign trip = cfg.limit_en & (below_now | above_now);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      below_low  <= 1'b0;
      above_high <= 1'b0;
      fault      <= 1'b0;
    end else begin
      below_low  <= below_now;  // Flags follow the position
      above_high <= above_now;
      if (fault_clear) begin
        fault <= 1'b0;  // Clear beats a new trip
      end else if (trip) begin
        fault <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/axis_regs.sv
// ##################################################
// Register bank of the axis. Plain write and read
// strobes, writes act at the sampling edge and read
// data is registered one cycle after rd_en
// ##################################################
`default_nettype none

module axis_regs import axis_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      wr_en,
  input  logic      rd_en,
  input  reg_addr_t addr,
  input  reg_data_t wdata,
  input  pos_t      position,
  input  pos_t      probe_pos,
  input  logic      probe_valid,
  input  logic      below_low,
  input  logic      above_high,
  input  logic      fault,
  output reg_data_t rdata,
  output axis_cfg_t cfg,
  output logic      load,        // Preset pulse for the counter
  output pos_t      load_value,
  output pos_t      low_limit,
  output pos_t      high_limit,
  output logic      probe_clear,
  output logic      fault_clear
);

  axis_status_t status;     // Assembled status word
  axis_status_t w1c_bits;   // Write data seen as status bits
  reg_data_t    rd_mux;
  logic         wr_status;

  assign status.probe_valid = probe_valid;
  assign status.below_low   = below_low;
  assign status.above_high  = above_high;
  assign status.fault       = fault;

  assign w1c_bits  = axis_status_t'(wdata[$bits(axis_status_t)-1:0]);
  assign wr_status = wr_en && (addr == ADDR_STATUS);

  // Pulses act at the same edge as the write
  assign load        = wr_en && (addr == ADDR_POSITION);
  assign load_value  = pos_t'(wdata);
  assign probe_clear = wr_status & w1c_bits.probe_valid;  // Bit 0
  assign fault_clear = wr_status & w1c_bits.fault;        // Bit 3

  // Config and limits
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cfg        <= '0;       // Counting off, falling edges
      low_limit  <= POS_MIN;  // Window wide open
      high_limit <= POS_MAX;
    end else if (wr_en) begin
      case (addr)
        ADDR_CTRL: begin
          cfg <= axis_cfg_t'(wdata[$bits(axis_cfg_t)-1:0]);
        end
        ADDR_LIMIT_LOW: begin
          low_limit <= pos_t'(wdata);
        end
        ADDR_LIMIT_HIGH: begin
          high_limit <= pos_t'(wdata);
        end
        default: begin
          // POSITION and STATUS act through pulses, PROBE_POS is read only
        end
      endcase
    end
  end

  // Read mux, narrow registers are zero extended
  always_comb begin
    rd_mux = '0;
    case (addr)
      ADDR_CTRL: begin
        rd_mux[$bits(axis_cfg_t)-1:0] = cfg;
      end
      ADDR_POSITION: begin
        rd_mux = reg_data_t'(position);
      end
      ADDR_LIMIT_LOW: begin
        rd_mux = reg_data_t'(low_limit);
      end
      ADDR_LIMIT_HIGH: begin
        rd_mux = reg_data_t'(high_limit);
      end
      ADDR_PROBE_POS: begin
        rd_mux = reg_data_t'(probe_pos);
      end
      ADDR_STATUS: begin
        rd_mux[$bits(axis_status_t)-1:0] = status;
      end
      default: begin
        rd_mux = '0;  // Unused addresses
      end
    endcase
  end

  // Sampled before any write of the same edge lands
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rdata <= '0;
    end else if (rd_en) begin
      rdata <= rd_mux;  // Holds until the next read
    end
  end

endmodule

`default_nettype wire

// File: design/pos_axis_top.sv
// ##################################################
// Position feedback axis. Step/dir counter, probe
// capture and soft limits behind a small register
// bank. SYNC_STAGES sets both input synchronizers
// ##################################################
`default_nettype none

module pos_axis_top import axis_pkg::*; #(
  parameter int SYNC_STAGES = 2  // Input synchronizer depth, two or more
) (
  input  logic      clk,
  input  logic      resetn,
  input  logic      step,    // Step line of the driver
  input  logic      dir,     // Direction line of the driver
  input  logic      probe,   // Touch probe input
  input  logic      wr_en,
  input  logic      rd_en,
  input  reg_addr_t addr,
  input  reg_data_t wdata,
  output reg_data_t rdata,
  output logic      fault    // Sticky soft limit fault
);

  axis_cfg_t cfg;
  logic      load;
  pos_t      load_value;
  pos_t      position;
  pos_t      low_limit;
  pos_t      high_limit;
  logic      probe_clear;
  logic      fault_clear;
  pos_t      probe_pos;
  logic      probe_valid;
  logic      below_low;
  logic      above_high;

  axis_regs regs_i (
    .clk         (clk),
    .resetn      (resetn),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .addr        (addr),
    .wdata       (wdata),
    .position    (position),
    .probe_pos   (probe_pos),
    .probe_valid (probe_valid),
    .below_low   (below_low),
    .above_high  (above_high),
    .fault       (fault),
    .rdata       (rdata),
    .cfg         (cfg),
    .load        (load),
    .load_value  (load_value),
    .low_limit   (low_limit),
    .high_limit  (high_limit),
    .probe_clear (probe_clear),
    .fault_clear (fault_clear)
  );

  pos_counter #(.SYNC_STAGES(SYNC_STAGES)) counter_i (
    .clk        (clk),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .cfg        (cfg),
    .load       (load),
    .load_value (load_value),
    .position   (position)
  );

  probe_latch #(.SYNC_STAGES(SYNC_STAGES)) probe_i (
    .clk         (clk),
    .resetn      (resetn),
    .probe       (probe),
    .cfg         (cfg),
    .position    (position),
    .probe_clear (probe_clear),
    .probe_pos   (probe_pos),
    .probe_valid (probe_valid)
  );

  limit_monitor limit_i (
    .clk         (clk),
    .resetn      (resetn),
    .position    (position),
    .low_limit   (low_limit),
    .high_limit  (high_limit),
    .cfg         (cfg),
    .fault_clear (fault_clear),
    .below_low   (below_low),
    .above_high  (above_high),
    .fault       (fault)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// ##################################################
// Clock and reset source of the axis testbench
// 20 ns clock, resetn held low for 16 cycles
// ##################################################
`default_nettype none

module tb_clock (
  output logic clk,
  output logic resetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    resetn = 1'b0;
    repeat (16) @(posedge clk);
    resetn <= 1'b1;  // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: tests/pos_axis_assert.sv
// ##################################################
// Concurrent checks on the axis top level, attached
// to every pos_axis_top by the bind at the bottom
// ##################################################
`default_nettype none

module pos_axis_assert import axis_pkg::*; (
  input logic      clk,
  input logic      resetn,
  input logic      load,      // Preset pulse inside the top level
  input pos_t      position,
  input axis_cfg_t cfg,
  input logic      fault,
  input logic      wr_en,
  input reg_addr_t addr,
  input reg_data_t wdata
);
  timeunit 1ns;
  timeprecision 100ps;

  logic status_clear;  // STATUS write with bit 3 set

  assign status_clear = wr_en && (addr == ADDR_STATUS) && wdata[3];

  // Without a preset the count moves by one at most
  step_bounded: assert property (@(posedge clk) disable iff (!resetn)
    ($past(resetn) && !$past(load)) |->
      ((position == $past(position)) || (position == $past(position) + pos_t'(1))
       || (position == $past(position) - pos_t'(1))))
    else $error("position moved by more than one step without a preset");

  fault_gated: assert property (@(posedge clk) disable iff (!resetn)
    $rose(fault) |-> $past(cfg.limit_en))
    else $error("fault rose while limit_en was clear");

  // Only a W1C of bit 3 releases the fault
  fault_sticky: assert property (@(posedge clk) disable iff (!resetn)
    $fell(fault) |-> $past(status_clear))
    else $error("fault fell without a STATUS write of bit 3");

endmodule

bind pos_axis_top pos_axis_assert assert_i (
  .clk      (clk),
  .resetn   (resetn),
  .load     (load),
  .position (position),
  .cfg      (cfg),
  .fault    (fault),
  .wr_en    (wr_en),
  .addr     (addr),
  .wdata    (wdata)
);

`default_nettype wire

// File: tests/pos_axis_tb.sv
// ##################################################
// Testbench of the position axis. Applies a table of
// register, step burst and probe operations and
// compares every read with a model of the axis
// ##################################################
`default_nettype none

module pos_axis_tb import axis_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SYNC_STAGES   = 2;
  localparam int HOLD_CYCLES   = 4;                // Step and probe levels hold this long
  localparam int SETTLE_CYCLES = SYNC_STAGES + 3;  // Sync, count stage and flag register
  localparam int WAIT_LIMIT    = 200;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_STEPS, OP_PROBE} op_kind_t;

  typedef struct packed {
    op_kind_t   kind;
    reg_addr_t  addr;
    reg_data_t  data;       // Write data or expected read value
    logic       use_model;  // Expected value comes from the model
    logic       level;      // Active step level, or new probe level
    logic       dir;
    logic [7:0] count;      // Pulses per burst, 0 picks a random count
  } op_row_t;

  logic         clk;
  logic         resetn;
  logic         step, dir, probe;
  logic         wr_en, rd_en;
  reg_addr_t    addr;
  reg_data_t    wdata, rdata;
  logic         fault;
  logic [1:0]   lines_q = '0;    // Step and probe seen at the last edge
  int           quiet_cycles = 0;
  axis_cfg_t    m_cfg;           // Model of the axis
  pos_t         m_pos, m_low, m_high, m_probe_pos;
  axis_status_t m_status;
  op_row_t      ops[$];

  tb_clock clock_i (.clk(clk), .resetn(resetn));

  pos_axis_top #(.SYNC_STAGES(SYNC_STAGES)) dut_i (
    .clk(clk), .resetn(resetn), .step(step), .dir(dir), .probe(probe), .wr_en(wr_en),
    .rd_en(rd_en), .addr(addr), .wdata(wdata), .rdata(rdata), .fault(fault)
  );

  always @(posedge clk) begin
    lines_q      <= {step, probe};
    quiet_cycles <= ({step, probe} != lines_q) ? 0 : quiet_cycles + 1;  // Input line activity
  end

  task automatic fail_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
    assert (act === exp) else begin
      $display("[ERROR] %0d ns %s expected 0x%h actual 0x%h", $time, name, exp, act);
      fail_run();
    end
  endtask

  // Flags follow the position, fault latches while limit_en is on
  function automatic void update_flags();
    m_status.below_low  = m_pos < m_low;
    m_status.above_high = m_pos > m_high;
    if (m_cfg.limit_en && (m_status.below_low || m_status.above_high)) m_status.fault = 1'b1;
  endfunction

  function automatic void model_write(input reg_addr_t a, input reg_data_t d);
    case (a)
      ADDR_CTRL:       m_cfg = axis_cfg_t'(d[$bits(axis_cfg_t)-1:0]);
      ADDR_POSITION:   m_pos = pos_t'(d);
      ADDR_LIMIT_LOW:  m_low = pos_t'(d);
      ADDR_LIMIT_HIGH: m_high = pos_t'(d);
      ADDR_STATUS: begin
        if (d[0]) m_status.probe_valid = 1'b0;  // Re-arm the probe
        if (d[3]) m_status.fault = 1'b0;
      end
      default: ;  // PROBE_POS is read only
    endcase
    update_flags();
  endfunction

  function automatic reg_data_t model_read(input reg_addr_t a);
    case (a)
      ADDR_CTRL:      return reg_data_t'(m_cfg);
      ADDR_POSITION:  return reg_data_t'(m_pos);
      ADDR_PROBE_POS: return reg_data_t'(m_probe_pos);
      ADDR_STATUS:    return reg_data_t'(m_status);
      default:        return '0;
    endcase
  endfunction

  task automatic wait_settle();
    int guard;
    guard = 0;
    while (quiet_cycles < SETTLE_CYCLES) begin
      @(posedge clk);
      guard++;
      if (guard > WAIT_LIMIT) begin
        $display("Timeout while waiting for the step and probe lines to settle");
        fail_run();
      end
    end
  endtask

  task automatic drive_step(input logic level);
    @(posedge clk);
    if (level != step && level == m_cfg.step_active_high && m_cfg.enable) begin
      m_pos = (dir ^ m_cfg.invert_dir) ? m_pos + pos_t'(1) : m_pos - pos_t'(1);
      update_flags();
    end
    step <= level;
    repeat (HOLD_CYCLES - 1) @(posedge clk);
  endtask

  task automatic run_burst(input op_row_t row);
    int n;
    n = (row.count == 0) ? 1 + ($urandom % 8) : int'(row.count);
    @(posedge clk);
    dir <= row.dir;  // Stable well before the first edge
    drive_step(~row.level);  // Idle level first
    repeat (n) begin
      drive_step(row.level);
      drive_step(~row.level);
    end
    wait_settle();
  endtask

  task automatic drive_probe(input logic level);
    @(posedge clk);
    if (level != probe && level == m_cfg.probe_rising && !m_status.probe_valid) begin
      m_probe_pos = m_pos;  // First selected edge captures
      m_status.probe_valid = 1'b1;
    end
    probe <= level;
    repeat (HOLD_CYCLES - 1) @(posedge clk);
    wait_settle();
  endtask

  task automatic do_write(input op_row_t row);
    @(posedge clk);
    wr_en <= 1'b1;
    addr  <= row.addr;
    wdata <= row.data;
    @(posedge clk);
    wr_en <= 1'b0;
    model_write(row.addr, row.data);
  endtask

  task automatic do_read(input op_row_t row);
    reg_data_t exp;
    exp = row.use_model ? model_read(row.addr) : row.data;
    @(posedge clk);
    rd_en <= 1'b1;
    addr  <= row.addr;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);  // rdata registered at the last rising edge
    check_value($sformatf("rdata@%0d", row.addr), exp, rdata);
    check_value("fault", reg_data_t'(m_status.fault), reg_data_t'(fault));
  endtask

  function automatic op_row_t reg_write(input reg_addr_t a, input reg_data_t d);
    return '{kind: OP_WRITE, addr: a, data: d, default: '0};
  endfunction

  function automatic op_row_t reg_read(input reg_addr_t a, input reg_data_t d);
    return '{kind: OP_READ, addr: a, data: d, default: '0};
  endfunction

  function automatic op_row_t reg_check(input reg_addr_t a);
    return '{kind: OP_READ, addr: a, use_model: 1'b1, default: '0};
  endfunction

  function automatic op_row_t step_burst(input logic lvl, input logic dr, input logic [7:0] n);
    return '{kind: OP_STEPS, level: lvl, dir: dr, count: n, default: '0};
  endfunction

  function automatic op_row_t probe_edge(input logic lvl);
    return '{kind: OP_PROBE, level: lvl, default: '0};
  endfunction

  function automatic void fill_table();
    ops = '{reg_read(ADDR_CTRL, 0), reg_read(ADDR_POSITION, 0), reg_read(ADDR_STATUS, 0),
      reg_read(ADDR_PROBE_POS, 0), step_burst(0, 1, 3), reg_read(ADDR_POSITION, 0),
      // Counting in all polarity and direction modes
      reg_write(ADDR_CTRL, 32'h01), step_burst(0, 1, 5), reg_check(ADDR_POSITION),
      step_burst(0, 0, 0), reg_check(ADDR_POSITION), reg_write(ADDR_CTRL, 32'h03),
      step_burst(1, 1, 0), reg_check(ADDR_POSITION), step_burst(0, 0, 3),
      reg_check(ADDR_POSITION), reg_write(ADDR_CTRL, 32'h07), step_burst(1, 1, 0),
      reg_check(ADDR_POSITION), step_burst(1, 0, 4), reg_check(ADDR_POSITION),
      reg_write(ADDR_CTRL, 32'h05), step_burst(0, 0, 0), reg_check(ADDR_POSITION),
      step_burst(0, 1, 2), reg_check(ADDR_POSITION),
      // Preset, then -20 plus 6 steps
      reg_write(ADDR_POSITION, 1000), reg_read(ADDR_POSITION, 1000),
      reg_write(ADDR_POSITION, 32'hFFFF_FFEC), reg_read(ADDR_POSITION, 32'hFFFF_FFEC),
      step_burst(0, 0, 6), reg_read(ADDR_POSITION, 32'hFFFF_FFF2),
      // Window -16 to 10, leave low side and high side
      reg_write(ADDR_LIMIT_LOW, 32'hFFFF_FFF0), reg_write(ADDR_LIMIT_HIGH, 10),
      reg_read(ADDR_LIMIT_LOW, 32'hFFFF_FFF0), reg_read(ADDR_LIMIT_HIGH, 10),
      reg_write(ADDR_CTRL, 32'h15), reg_read(ADDR_STATUS, 0), step_burst(0, 1, 4),
      reg_read(ADDR_STATUS, 32'hA), step_burst(0, 0, 4), reg_read(ADDR_STATUS, 32'h8),
      reg_write(ADDR_STATUS, 32'h8), reg_read(ADDR_STATUS, 0), reg_write(ADDR_POSITION, 8),
      step_burst(0, 0, 5), reg_read(ADDR_STATUS, 32'hC), step_burst(0, 1, 5),
      reg_read(ADDR_STATUS, 32'h8), reg_write(ADDR_STATUS, 32'h8), reg_read(ADDR_STATUS, 0),
      // Probe capture at 8, second edge ignored, re-arm and capture at 5
      reg_write(ADDR_CTRL, 32'h1D), probe_edge(1), reg_read(ADDR_PROBE_POS, 8),
      reg_read(ADDR_STATUS, 32'h1), step_burst(0, 1, 3), probe_edge(0), probe_edge(1),
      reg_read(ADDR_PROBE_POS, 8), reg_write(ADDR_STATUS, 32'h1), reg_read(ADDR_STATUS, 0),
      probe_edge(0), reg_read(ADDR_STATUS, 0), probe_edge(1), reg_read(ADDR_PROBE_POS, 5),
      reg_check(ADDR_STATUS),
      // Read only and unused addresses
      reg_write(ADDR_PROBE_POS, 32'h1234), reg_read(ADDR_PROBE_POS, 5), reg_read(3'd6, 0),
      reg_read(3'd7, 0), reg_read(ADDR_CTRL, 32'h1D)};
  endfunction

  initial begin
    int guard;
    step  = 1'b0;
    dir   = 1'b0;
    probe = 1'b0;
    wr_en = 1'b0;
    rd_en = 1'b0;
    addr  = '0;
    wdata = '0;
    m_cfg       = '0;  // Reset state of the axis
    m_pos       = '0;
    m_low       = POS_MIN;
    m_high      = POS_MAX;
    m_probe_pos = '0;
    m_status    = '0;
    void'($urandom(32'h903e833e));
    fill_table();
    guard = 0;
    while (resetn !== 1'b1) begin
      @(posedge clk);
      guard++;
      if (guard > WAIT_LIMIT) begin
        $display("Timeout while waiting for reset release");
        fail_run();
      end
    end
    foreach (ops[i]) begin
      case (ops[i].kind)
        OP_WRITE: do_write(ops[i]);
        OP_READ:  do_read(ops[i]);
        OP_STEPS: run_burst(ops[i]);
        default:  drive_probe(ops[i].level);
      endcase
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
design/axis_pkg.sv
design/pos_counter.sv
design/probe_latch.sv
design/limit_monitor.sv
design/axis_regs.sv
design/pos_axis_top.sv
tests/tb_clock.sv
tests/pos_axis_assert.sv
tests/pos_axis_tb.sv

// File: Makefile
# Verilator flow for the position axis
# make lint  : static checks of RTL and testbench
# make sim   : build, run, and pass only if the log shows the pass message
# make clean : remove build output and log

TOP = pos_axis_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

sim:
	rm -f sim.log
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
